/* logic/axi_mem_config.svh */
// ======================================================================
// Width and depth settings of the AXI memory bridge
// ======================================================================
`ifndef AXI_MEM_CONFIG_SVH
`define AXI_MEM_CONFIG_SVH

// Byte address width
`define AXI_MEM_ADDR_WIDTH 16

// Beat width in bits
`define AXI_MEM_DATA_WIDTH 32

// Transaction ID width
`define AXI_MEM_ID_WIDTH 4

// Entries of the metadata and read data buffers
`define AXI_MEM_BUF_DEPTH 4

`endif

/* logic/axi_mem_pkg.sv */
// ======================================================================
// Shared types of the AXI memory bridge
// ======================================================================
`default_nettype none
`include "axi_mem_config.svh"

package axi_mem_pkg;

  // Bytes per beat and address step between beats
  localparam int unsigned DataBytes = `AXI_MEM_DATA_WIDTH / 8;

  typedef logic [`AXI_MEM_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_MEM_DATA_WIDTH-1:0] data_t;
  typedef logic [DataBytes-1:0]           strb_t;
  typedef logic [`AXI_MEM_ID_WIDTH-1:0]   id_t;
  // Number of beats minus one
  typedef logic [7:0]                     len_t;

  // One memory beat on its way from the arbiter to R or B
  typedef struct packed {
    addr_t addr;
    id_t   id;
    logic  last;
    logic  write;
  } beat_meta_t;

endpackage

`default_nettype wire

/* logic/rd_burst_gen.sv */
// ======================================================================
// Read burst generator that splits one AR into single memory beats
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module rd_burst_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ar_valid_i,
  input  axi_mem_pkg::addr_t      ar_addr_i,
  input  axi_mem_pkg::len_t       ar_len_i,
  input  axi_mem_pkg::id_t        ar_id_i,
  output logic                    ar_ready_o,
  output logic                    beat_valid_o,
  output axi_mem_pkg::beat_meta_t beat_o,
  input  logic                    beat_ready_i,
  output logic                    burst_active_o
);

  axi_mem_pkg::len_t  cnt_q;
  axi_mem_pkg::addr_t addr_q;
  axi_mem_pkg::id_t   id_q;

  assign burst_active_o = (cnt_q != '0);

  always_comb begin
    beat_o.write = 1'b0;
    if (burst_active_o) begin
      // Next aligned address of the open burst
      beat_o.addr  = addr_q + axi_mem_pkg::addr_t'(axi_mem_pkg::DataBytes);
      beat_o.id    = id_q;
      beat_o.last  = (cnt_q == 8'd1);
      beat_valid_o = 1'b1;
    end else begin
      // First beat comes straight from AR
      beat_o.addr  = ar_addr_i;
      beat_o.id    = ar_id_i;
      beat_o.last  = (ar_len_i == '0);
      beat_valid_o = ar_valid_i;
    end
  end

  assign ar_ready_o = !burst_active_o && ar_valid_i && beat_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (ar_ready_o) begin
      cnt_q <= ar_len_i;
    end else if (burst_active_o && beat_ready_i) begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_ready_o) begin
      addr_q <= ar_addr_i & ~axi_mem_pkg::addr_t'(axi_mem_pkg::DataBytes - 1);
      id_q   <= ar_id_i;
    end else if (burst_active_o && beat_ready_i) begin
      addr_q <= beat_o.addr;
    end
  end

endmodule

`default_nettype wire

/* logic/wr_burst_gen.sv */
// ======================================================================
// Write burst generator that pairs one AW with its W beats
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module wr_burst_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    aw_valid_i,
  input  axi_mem_pkg::addr_t      aw_addr_i,
  input  axi_mem_pkg::len_t       aw_len_i,
  input  axi_mem_pkg::id_t        aw_id_i,
  output logic                    aw_ready_o,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output logic                    beat_valid_o,
  output axi_mem_pkg::beat_meta_t beat_o,
  input  logic                    beat_ready_i,
  output logic                    burst_active_o
);

  axi_mem_pkg::len_t  cnt_q;
  axi_mem_pkg::addr_t addr_q;
  axi_mem_pkg::id_t   id_q;
  logic               beat_acc;

  assign burst_active_o = (cnt_q != '0);

  always_comb begin
    beat_o.write = 1'b1;
    if (burst_active_o) begin
      beat_o.addr  = addr_q + axi_mem_pkg::addr_t'(axi_mem_pkg::DataBytes);
      beat_o.id    = id_q;
      beat_o.last  = (cnt_q == 8'd1);
      beat_valid_o = w_valid_i;
    end else begin
      // First beat waits for both AW and its W data
      beat_o.addr  = aw_addr_i;
      beat_o.id    = aw_id_i;
      beat_o.last  = (aw_len_i == '0);
      beat_valid_o = aw_valid_i && w_valid_i;
    end
  end

  assign beat_acc   = beat_valid_o && beat_ready_i;
  assign w_ready_o  = beat_acc;
  assign aw_ready_o = beat_acc && !burst_active_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (aw_ready_o) begin
      cnt_q <= aw_len_i;
    end else if (burst_active_o && beat_acc) begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_ready_o) begin
      addr_q <= aw_addr_i & ~axi_mem_pkg::addr_t'(axi_mem_pkg::DataBytes - 1);
      id_q   <= aw_id_i;
    end else if (burst_active_o && beat_acc) begin
      addr_q <= beat_o.addr;
    end
  end

endmodule

`default_nettype wire

/* logic/beat_arbiter.sv */
// ======================================================================
// Read/write beat arbiter driving the memory request
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module beat_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rd_valid_i,
  input  axi_mem_pkg::beat_meta_t rd_beat_i,
  input  logic                    rd_active_i,
  output logic                    rd_ready_o,
  input  logic                    wr_valid_i,
  input  axi_mem_pkg::beat_meta_t wr_beat_i,
  input  logic                    wr_active_i,
  output logic                    wr_ready_o,
  input  logic                    meta_room_i,
  output logic                    mem_req_o,
  input  logic                    mem_gnt_i,
  output axi_mem_pkg::beat_meta_t beat_o,
  output logic                    push_o
);

  // Selection is 1 for the write side
  logic sel_d, sel_q;
  logic lock_q;

  always_comb begin
    sel_d = sel_q;
    if (!lock_q) begin
      if (rd_valid_i ^ wr_valid_i) begin
        sel_d = wr_valid_i;
      end else if (rd_valid_i && wr_valid_i) begin
        // Single writes slip in between read beats, but only after a read grant
        if (wr_beat_i.last && !rd_beat_i.last && !sel_q) begin
          sel_d = 1'b1;
        end else if (wr_active_i) begin
          sel_d = 1'b1;
        end else if (rd_active_i) begin
          sel_d = 1'b0;
        end else begin
          sel_d = ~sel_q;
        end
      end
    end
  end

  assign beat_o     = sel_d ? wr_beat_i : rd_beat_i;
  assign mem_req_o  = (sel_d ? wr_valid_i : rd_valid_i) && meta_room_i;
  assign push_o     = mem_req_o && mem_gnt_i;
  assign rd_ready_o = push_o && !sel_d;
  assign wr_ready_o = push_o && sel_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel_d;
      // Hold the choice while the request waits for its grant
      lock_q <= mem_req_o && !mem_gnt_i;
    end
  end

endmodule

`default_nettype wire

/* logic/stream_fifo.sv */
// ======================================================================
// Registered-output FIFO with a type parameter for its entries
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  T                mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            do_push, do_pop;

  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* logic/resp_unit.sv */
// ======================================================================
// Response unit joining beat metadata with memory data for R and B
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module resp_unit (
  input  axi_mem_pkg::beat_meta_t meta_i,
  input  logic                    meta_empty_i,
  input  axi_mem_pkg::data_t      rdata_i,
  input  logic                    data_empty_i,
  output logic                    pop_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output axi_mem_pkg::data_t      r_data_o,
  output axi_mem_pkg::id_t        r_id_o,
  output logic                    r_last_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output axi_mem_pkg::id_t        b_id_o
);

  logic head_valid;

  // A beat is complete once both heads are present
  assign head_valid = !meta_empty_i && !data_empty_i;

  assign r_valid_o = head_valid && !meta_i.write;
  assign b_valid_o = head_valid && meta_i.write && meta_i.last;

  // Non-final write beats only retire their memory response
  always_comb begin
    if (!meta_i.write) begin
      pop_o = head_valid && r_ready_i;
    end else if (meta_i.last) begin
      pop_o = head_valid && b_ready_i;
    end else begin
      pop_o = head_valid;
    end
  end

  assign r_data_o = rdata_i;
  assign r_id_o   = meta_i.id;
  assign r_last_o = meta_i.last;
  assign b_id_o   = meta_i.id;

endmodule

`default_nettype wire

/* logic/axi_mem_bridge.sv */
// ======================================================================
// AXI to single-port memory bridge, top level
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "axi_mem_config.svh"

module axi_mem_bridge (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  axi_mem_pkg::addr_t      ar_addr_i,
  input  axi_mem_pkg::len_t       ar_len_i,
  input  axi_mem_pkg::id_t        ar_id_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  axi_mem_pkg::addr_t      aw_addr_i,
  input  axi_mem_pkg::len_t       aw_len_i,
  input  axi_mem_pkg::id_t        aw_id_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  axi_mem_pkg::data_t      w_data_i,
  input  axi_mem_pkg::strb_t      w_strb_i,
  input  logic                    w_last_i,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output axi_mem_pkg::data_t      r_data_o,
  output axi_mem_pkg::id_t        r_id_o,
  output logic                    r_last_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output axi_mem_pkg::id_t        b_id_o,
  output logic                    mem_req_o,
  input  logic                    mem_gnt_i,
  output axi_mem_pkg::addr_t      mem_addr_o,
  output axi_mem_pkg::data_t      mem_wdata_o,
  output axi_mem_pkg::strb_t      mem_strb_o,
  output logic                    mem_we_o,
  input  logic                    mem_rvalid_i,
  input  axi_mem_pkg::data_t      mem_rdata_i,
  output logic                    busy_o
);

  axi_mem_pkg::beat_meta_t rd_beat, wr_beat, mem_beat, meta_head;
  axi_mem_pkg::data_t      data_head;
  logic rd_valid, rd_ready, rd_active;
  logic wr_valid, wr_ready, wr_active;
  logic meta_full, meta_empty, data_empty;
  logic push, pop;

  rd_burst_gen i_rd_gen (
    .clk_i, .rst_ni,
    .ar_valid_i, .ar_addr_i, .ar_len_i, .ar_id_i, .ar_ready_o,
    .beat_valid_o   (rd_valid),
    .beat_o         (rd_beat),
    .beat_ready_i   (rd_ready),
    .burst_active_o (rd_active)
  );

  wr_burst_gen i_wr_gen (
    .clk_i, .rst_ni,
    .aw_valid_i, .aw_addr_i, .aw_len_i, .aw_id_i, .aw_ready_o,
    .w_valid_i, .w_ready_o,
    .beat_valid_o   (wr_valid),
    .beat_o         (wr_beat),
    .beat_ready_i   (wr_ready),
    .burst_active_o (wr_active)
  );

  beat_arbiter i_arbiter (
    .clk_i, .rst_ni,
    .rd_valid_i  (rd_valid),
    .rd_beat_i   (rd_beat),
    .rd_active_i (rd_active),
    .rd_ready_o  (rd_ready),
    .wr_valid_i  (wr_valid),
    .wr_beat_i   (wr_beat),
    .wr_active_i (wr_active),
    .wr_ready_o  (wr_ready),
    .meta_room_i (!meta_full),
    .mem_req_o,
    .mem_gnt_i,
    .beat_o      (mem_beat),
    .push_o      (push)
  );

  // Memory side of the chosen beat
  // W payload is held by the master until its grant
  assign mem_addr_o  = mem_beat.addr;
  assign mem_we_o    = mem_beat.write;
  assign mem_wdata_o = w_data_i;
  assign mem_strb_o  = w_strb_i;

  stream_fifo #(.T(axi_mem_pkg::beat_meta_t), .Depth(`AXI_MEM_BUF_DEPTH)) i_meta_fifo (
    .clk_i, .rst_ni,
    .push_i  (push),
    .data_i  (mem_beat),
    .full_o  (meta_full),
    .pop_i   (pop),
    .data_o  (meta_head),
    .empty_o (meta_empty)
  );

  // Never holds more entries than the metadata FIFO
  stream_fifo #(.T(axi_mem_pkg::data_t), .Depth(`AXI_MEM_BUF_DEPTH)) i_data_fifo (
    .clk_i, .rst_ni,
    .push_i  (mem_rvalid_i),
    .data_i  (mem_rdata_i),
    .full_o  (),
    .pop_i   (pop),
    .data_o  (data_head),
    .empty_o (data_empty)
  );

  resp_unit i_resp (
    .meta_i       (meta_head),
    .meta_empty_i (meta_empty),
    .rdata_i      (data_head),
    .data_empty_i (data_empty),
    .pop_o        (pop),
    .r_valid_o, .r_ready_i, .r_data_o, .r_id_o, .r_last_o,
    .b_valid_o, .b_ready_i, .b_id_o
  );

  assign busy_o = ar_valid_i || aw_valid_i || w_valid_i ||
                  rd_active || wr_active || !meta_empty || !data_empty;

endmodule

`default_nettype wire

/* testbench/axi_mem_assert.sv */
// ======================================================================
// Handshake stability checks for the AXI memory bridge, bound to the DUT
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module axi_mem_assert (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               r_valid_i, r_ready_i, r_last_i,
  input axi_mem_pkg::data_t r_data_i,
  input axi_mem_pkg::id_t   r_id_i,
  input logic               b_valid_i, b_ready_i,
  input axi_mem_pkg::id_t   b_id_i,
  input logic               mem_req_i, mem_gnt_i, mem_we_i,
  input axi_mem_pkg::addr_t mem_addr_i,
  input logic               w_valid_i, w_ready_i, w_last_i
);

  // Final W beats accepted but not yet answered on B
  logic [7:0] open_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q <= '0;
    end else begin
      open_q <= open_q + 8'(w_valid_i && w_ready_i && w_last_i) - 8'(b_valid_i && b_ready_i);
    end
  end

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable({r_data_i, r_id_i, r_last_i}))
    else $error("R payload changed while stalled");

  b_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_id_i))
    else $error("B payload changed while stalled");

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable({mem_addr_i, mem_we_i}))
    else $error("Memory request dropped or changed before its grant");

  b_after_w: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i |-> open_q != '0)
    else $error("B valid before the last W beat was accepted");

endmodule

bind axi_mem_bridge axi_mem_assert i_assert (
  .clk_i, .rst_ni,
  .r_valid_i (r_valid_o), .r_ready_i (r_ready_i), .r_last_i (r_last_o),
  .r_data_i  (r_data_o),  .r_id_i    (r_id_o),
  .b_valid_i (b_valid_o), .b_ready_i (b_ready_i), .b_id_i (b_id_o),
  .mem_req_i (mem_req_o), .mem_gnt_i (mem_gnt_i), .mem_we_i (mem_we_o),
  .mem_addr_i (mem_addr_o),
  .w_valid_i (w_valid_i), .w_ready_i (w_ready_o), .w_last_i (w_last_i)
);

`default_nettype wire

/* testbench/tb_axi_mem_bridge.sv */
// ======================================================================
// Testbench for the AXI memory bridge with memory model, checker, watchdog
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_bridge;

  localparam int unsigned Words = (2 ** $bits(axi_mem_pkg::addr_t)) / axi_mem_pkg::DataBytes;

  logic clk_i, rst_ni;
  logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
  logic r_valid_o, r_ready_i, r_last_o, b_valid_o, b_ready_i, busy_o;
  logic mem_req_o, mem_gnt_i, mem_we_o, mem_rvalid_i;
  axi_mem_pkg::addr_t ar_addr_i, aw_addr_i, mem_addr_o;
  axi_mem_pkg::len_t  ar_len_i, aw_len_i;
  axi_mem_pkg::id_t   ar_id_i, aw_id_i, r_id_o, b_id_o;
  axi_mem_pkg::data_t w_data_i, r_data_o, mem_wdata_o, mem_rdata_i;
  axi_mem_pkg::strb_t w_strb_i, mem_strb_o;

  axi_mem_pkg::data_t model_mem [Words];
  axi_mem_pkg::data_t shadow [Words];
  axi_mem_pkg::data_t rd_word = '0;
  logic   gnt_seen = 1'b0;
  logic   stall_en = 1'b0;
  integer seed = 2;
  string  test_name = "reset";
  int     mismatches = 0;
  int     unexpected = 0;
  int     beats_issued = 0;
  int     cycles = 0;

  // Expected responses in issue order
  axi_mem_pkg::data_t r_exp_data [$];
  axi_mem_pkg::id_t   r_exp_id [$];
  logic               r_exp_last [$];
  axi_mem_pkg::id_t   b_exp_id [$];

  axi_mem_bridge dut (.*);

  function automatic axi_mem_pkg::data_t fill_word(int unsigned idx);
    return axi_mem_pkg::data_t'(idx * 32'h9e3779b1) ^ 32'h5a5a0000;
  endfunction

  // Byte-wise merge of a write into the old word
  function automatic axi_mem_pkg::data_t expected_word(axi_mem_pkg::data_t old_word,
                                                       axi_mem_pkg::data_t new_word,
                                                       axi_mem_pkg::strb_t strb);
    axi_mem_pkg::data_t merged;
    merged = old_word;
    for (int b = 0; b < axi_mem_pkg::DataBytes; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic read_burst(axi_mem_pkg::addr_t addr, int unsigned beats, axi_mem_pkg::id_t id);
    int unsigned k;
    for (k = 0; k < beats; k++) begin
      r_exp_data.push_back(shadow[addr / axi_mem_pkg::DataBytes + k]);
      r_exp_id.push_back(id);
      r_exp_last.push_back(k == beats - 1);
    end
    beats_issued += beats;
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_len_i   = axi_mem_pkg::len_t'(beats - 1);
    ar_id_i    = id;
    do @(posedge clk_i); while (!ar_ready_o);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    // The first beat still waits in the metadata FIFO for its data
    check_value("busy", 1'b1, busy_o);
  endtask

  task automatic write_burst(axi_mem_pkg::addr_t addr, int unsigned beats, axi_mem_pkg::id_t id);
    int unsigned k, idx;
    axi_mem_pkg::data_t data;
    axi_mem_pkg::strb_t strb;
    idx = addr / axi_mem_pkg::DataBytes;
    b_exp_id.push_back(id);
    beats_issued += beats;
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_len_i   = axi_mem_pkg::len_t'(beats - 1);
    aw_id_i    = id;
    for (k = 0; k < beats; k++) begin
      data      = $random(seed);
      strb      = axi_mem_pkg::strb_t'($random(seed));
      w_valid_i = 1'b1;
      w_data_i  = data;
      w_strb_i  = strb;
      w_last_i  = (k == beats - 1);
      do @(posedge clk_i); while (!w_ready_o);
      shadow[idx + k] = expected_word(shadow[idx + k], data, strb);
      // AW goes with the first W beat
      @(negedge clk_i);
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
    end
  endtask

  task automatic wait_idle();
    while (r_exp_data.size() != 0 || b_exp_id.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Memory model that writes at the grant and answers one cycle later
  initial begin
    for (int unsigned i = 0; i < Words; i++) begin
      model_mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk_i);
      gnt_seen = mem_req_o && mem_gnt_i;
      if (gnt_seen) begin
        rd_word = model_mem[mem_addr_o / axi_mem_pkg::DataBytes];
        if (mem_we_o) begin
          model_mem[mem_addr_o / axi_mem_pkg::DataBytes] =
            expected_word(rd_word, mem_wdata_o, mem_strb_o);
        end
      end
    end
  end

  initial begin
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    r_ready_i    = 1'b0;
    b_ready_i    = 1'b0;
    forever begin
      @(negedge clk_i);
      mem_rvalid_i = gnt_seen;
      mem_rdata_i  = rd_word;
      mem_gnt_i    = !stall_en || ($random(seed) % 4 != 0);
      r_ready_i    = !stall_en || ($random(seed) % 3 != 0);
      b_ready_i    = !stall_en || ($random(seed) % 3 != 0);
    end
  end

  always @(posedge clk_i) begin
    if (r_valid_o && r_ready_i) begin
      if (r_exp_data.size() == 0) begin
        unexpected++;
        $display("Read beat with ID %h arrived while no read was outstanding", r_id_o);
      end else begin
        check_value("r_data", r_exp_data.pop_front(), r_data_o);
        check_value("r_id", r_exp_id.pop_front(), r_id_o);
        check_value("r_last", r_exp_last.pop_front(), r_last_o);
      end
    end
    if (b_valid_o && b_ready_i) begin
      if (b_exp_id.size() == 0) begin
        unexpected++;
        $display("Write response with ID %h arrived while no write was outstanding", b_id_o);
      end else begin
        check_value("b_id", b_exp_id.pop_front(), b_id_o);
      end
    end
  end

  // Budget grows with every beat handed to the DUT
  initial begin
    while (cycles <= 200 * (beats_issued + 10)) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the DUT stopped answering after %0d cycles", cycles);
    $display("Errors: %0d mismatches, %0d unexpected responses", mismatches, unexpected);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    axi_mem_pkg::addr_t base, wbase;
    axi_mem_pkg::addr_t wr_base [$];
    int unsigned        wr_len [$];
    int unsigned        n, m, len, wlen;
    rst_ni     = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_id_i    = '0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    for (n = 0; n < Words; n++) begin
      shadow[n] = fill_word(n);
    end
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("r_valid", 1'b0, r_valid_o);
    check_value("b_valid", 1'b0, b_valid_o);
    check_value("mem_req", 1'b0, mem_req_o);
    check_value("busy", 1'b0, busy_o);
    check_value("ready", 3'b000, {ar_ready_o, aw_ready_o, w_ready_o});

    test_name = "single";
    for (n = 0; n < 8; n++) begin
      base = axi_mem_pkg::addr_t'($random(seed)) & 16'h0ffc;
      write_burst(base, 1, axi_mem_pkg::id_t'(n));
      read_burst(base, 1, axi_mem_pkg::id_t'(n + 8));
    end
    wait_idle();

    test_name = "read_burst";
    for (n = 0; n < 6; n++) begin
      len  = ($random(seed) & 255) + 1;
      base = axi_mem_pkg::addr_t'($random(seed)) & 16'h3ffc;
      read_burst(base, len, axi_mem_pkg::id_t'(n));
    end
    wait_idle();

    test_name = "write_burst";
    for (n = 0; n < 5; n++) begin
      len  = ($random(seed) & 255) + 1;
      base = 16'hc000 | (axi_mem_pkg::addr_t'($random(seed)) & 16'h3bfc);
      write_burst(base, len, axi_mem_pkg::id_t'(n + 3));
    end
    wait_idle();

    // Reads and writes on disjoint regions, with random stalls
    test_name = "mixed";
    stall_en  = 1'b1;
    fork
      begin
        for (n = 0; n < 6; n++) begin
          len  = ($random(seed) & 255) + 1;
          base = axi_mem_pkg::addr_t'($random(seed)) & 16'h3ffc;
          read_burst(base, len, axi_mem_pkg::id_t'(n));
        end
      end
      begin
        for (m = 0; m < 6; m++) begin
          wlen  = ($random(seed) & 255) + 1;
          wbase = 16'h8000 | (axi_mem_pkg::addr_t'($random(seed)) & 16'h3bfc);
          wr_base.push_back(wbase);
          wr_len.push_back(wlen);
          write_burst(wbase, wlen, axi_mem_pkg::id_t'(m + 6));
        end
      end
    join
    wait_idle();

    test_name = "read_back";
    for (n = 0; n < wr_base.size(); n++) begin
      read_burst(wr_base[n], wr_len[n], axi_mem_pkg::id_t'(n));
    end
    wait_idle();
    stall_en = 1'b0;

    test_name = "idle";
    repeat (2) @(negedge clk_i);
    check_value("busy", 1'b0, busy_o);

    $display("Errors: %0d mismatches, %0d unexpected responses", mismatches, unexpected);
    if (mismatches == 0 && unexpected == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/axi_mem_pkg.sv
logic/rd_burst_gen.sv
logic/wr_burst_gen.sv
logic/beat_arbiter.sv
logic/stream_fifo.sv
logic/resp_unit.sv
logic/axi_mem_bridge.sv
testbench/axi_mem_assert.sv
testbench/tb_axi_mem_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the AXI memory bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_axi_mem_bridge -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  && ! grep -qF "** FAIL **" sim.log \
  && echo "Simulation passed, log in sim.log" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
